// File: src/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Data path and bus width
`define XLEN 32

// First fetch address
`define RESET_PC 32'h0000_0000

// Architectural registers, x0 included
`define NREGS 32

`endif

// File: src/cpuPkg.sv
`include "cpu_consts.svh"

package cpuPkg;

    typedef logic [`XLEN-1:0] wordT;

    typedef enum logic [6:0] {
        opR      = 7'b0110011,  // Register ALU
        opLoad   = 7'b0000011,  // lbu only
        opIAlu   = 7'b0010011,  // Immediate ALU
        opStore  = 7'b0100011,  // sb only
        opBranch = 7'b1100011,  // beq, bne
        opAuipc  = 7'b0010111,
        opLui    = 7'b0110111,
        opJalr   = 7'b1100111,
        opJal    = 7'b1101111
    } opcodeT;

    typedef enum logic [3:0] {
        aluAdd  = 4'b0000,
        aluBne  = 4'b0001,
        aluJal  = 4'b0010,
        aluJalr = 4'b0011,
        aluLui  = 4'b0100,
        aluLbu  = 4'b0101,
        aluSb   = 4'b0110,
        aluSll  = 4'b0111,
        aluSub  = 4'b1000,
        aluSrl  = 4'b1001,
        aluXor  = 4'b1010,
        aluOr   = 4'b1011,
        aluAnd  = 4'b1100,
        aluBeq  = 4'b1101
    } aluOpT;

    typedef enum logic [2:0] {
        immI = 3'b000,
        immU = 3'b001,
        immS = 3'b010,
        immB = 3'b011,
        immJ = 3'b100
    } immTypeT;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcodeT     opcode;
    } rFieldsT;

    typedef struct packed {
        logic [11:0] imm12;  // Also carries rs2/funct7 bits for the other formats
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcodeT      opcode;
    } iFieldsT;

    typedef union packed {
        rFieldsT rView;
        iFieldsT iView;
    } instrT;

endpackage

// File: src/controlUnit.sv
module controlUnit import cpuPkg::*; (
    input  opcodeT      opcode,
    input  logic [2:0]  funct3,
    input  logic        funct7,     // Instruction bit 30
    output logic        regWrite,
    output aluOpT       aluCtrl,
    output logic        aluSrc,     // Immediate as second operand
    output immTypeT     immSrc,
    output logic        pcSrc,      // Branch or jump class
    output logic        memWrite,
    output logic        resultSrc,  // Load data to rd
    output logic        jumpSrc,    // jal or jalr, links pc + 4
    output logic        jRetSrc,    // jalr, target from ALU
    output logic        branch
);

    always_comb begin
        regWrite  = 1'b0;
        aluCtrl   = aluAdd;
        aluSrc    = 1'b0;
        immSrc    = immI;
        pcSrc     = 1'b0;
        memWrite  = 1'b0;
        resultSrc = 1'b0;
        jumpSrc   = 1'b0;
        jRetSrc   = 1'b0;
        branch    = 1'b0;

        case (opcode)
            opR, opIAlu: begin
                regWrite = 1'b1;
                aluSrc   = (opcode == opIAlu);
                case (funct3)
                    // Bit 30 is immediate data in addi, so sub only in R form
                    3'b000: aluCtrl = (opcode == opR && funct7) ? aluSub : aluAdd;
                    3'b001: aluCtrl = aluSll;
                    3'b100: aluCtrl = aluXor;
                    3'b101: aluCtrl = aluSrl;
                    3'b110: aluCtrl = aluOr;
                    3'b111: aluCtrl = aluAnd;
                    default: regWrite = 1'b0;  // slt, sltu run as nop
                endcase
            end
            opLoad: begin
                regWrite  = 1'b1;
                aluSrc    = 1'b1;
                resultSrc = 1'b1;
                aluCtrl   = aluLbu;
            end
            opStore: begin
                aluSrc   = 1'b1;
                memWrite = 1'b1;
                immSrc   = immS;
                aluCtrl  = aluSb;
            end
            opBranch: begin
                pcSrc  = 1'b1;
                branch = 1'b1;
                immSrc = immB;
                case (funct3)
                    3'b000:  aluCtrl = aluBeq;
                    3'b001:  aluCtrl = aluBne;
                    default: aluCtrl = aluAdd;  // Never taken
                endcase
            end
            opAuipc: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                immSrc   = immU;
            end
            opLui: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                immSrc   = immU;
                aluCtrl  = aluLui;
            end
            opJal: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                pcSrc    = 1'b1;
                jumpSrc  = 1'b1;
                immSrc   = immJ;
                aluCtrl  = aluJal;
            end
            opJalr: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                pcSrc    = 1'b1;
                jumpSrc  = 1'b1;
                jRetSrc  = 1'b1;
                aluCtrl  = aluJalr;  // rs1 + imm gives the target
            end
            default: ;  // Unknown opcode is a nop
        endcase
    end

endmodule

// File: src/immExtend.sv
module immExtend import cpuPkg::*; (
    input  instrT    instr,
    input  immTypeT  immSrc,
    output wordT     imm
);

    logic [11:0] hi12;
    logic [4:0]  lo5;
    logic [7:0]  mid8;

    assign hi12 = instr.iView.imm12;                        // Bits 31:20
    assign lo5  = instr.iView.rd;                           // Bits 11:7
    assign mid8 = {instr.iView.rs1, instr.iView.funct3};    // Bits 19:12

    always_comb begin
        case (immSrc)
            immI:    imm = {{20{hi12[11]}}, hi12};
            immS:    imm = {{20{hi12[11]}}, hi12[11:5], lo5};
            immB:    imm = {{20{hi12[11]}}, lo5[0], hi12[10:5], lo5[4:1], 1'b0};
            immU:    imm = {hi12, mid8, 12'b0};
            immJ:    imm = {{12{hi12[11]}}, mid8, hi12[0], hi12[10:1], 1'b0};
            default: imm = '0;
        endcase
    end

endmodule

// File: src/regFile.sv
`include "cpu_consts.svh"

module regFile import cpuPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic        wrEn,
    input  wordT        wrData,
    output wordT        rd1,
    output wordT        rd2
);

    wordT regs [`NREGS];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && rd != 5'd0) begin  // x0 stays zero
            regs[rd] <= wrData;
        end
    end

    // Combinational read, x0 forced to zero
    assign rd1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// File: src/alu.sv
`include "cpu_consts.svh"

module alu import cpuPkg::*; (
    input  aluOpT  aluCtrl,
    input  wordT   srcA,
    input  wordT   srcB,
    output wordT   result,
    output logic   zero      // Branch condition holds
);

    localparam int ShW = $clog2(`XLEN);

    logic [ShW-1:0] shamt;

    assign shamt = srcB[ShW-1:0];

    always_comb begin
        result = srcA + srcB;  // add, lbu, sb, jal, jalr
        zero   = 1'b0;
        case (aluCtrl)
            aluSub: result = srcA - srcB;
            aluSll: result = srcA << shamt;
            aluSrl: result = srcA >> shamt;
            aluXor: result = srcA ^ srcB;
            aluOr:  result = srcA | srcB;
            aluAnd: result = srcA & srcB;
            aluLui: result = srcB;
            aluBeq: begin
                result = srcA - srcB;
                zero   = (srcA == srcB);
            end
            aluBne: begin
                result = srcA - srcB;
                zero   = (srcA != srcB);
            end
            default: ;
        endcase
    end

endmodule

// File: src/cpuSequencer.sv
`include "cpu_consts.svh"

module cpuSequencer import cpuPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    output logic        cyc,
    output logic        stb,
    output logic        we,
    output wordT        adr,
    output wordT        datMosi,
    output logic [3:0]  sel,
    input  logic        ack,
    input  wordT        datMiso,
    output instrT       instr,      // Instruction register
    input  logic        regWrite,
    input  logic        aluSrc,
    input  logic        pcSrc,
    input  logic        memWrite,
    input  logic        resultSrc,
    input  logic        jumpSrc,
    input  logic        jRetSrc,
    input  logic        branch,
    input  wordT        imm,
    input  wordT        rd1,
    input  wordT        rd2,
    input  wordT        aluResult,
    input  logic        zero,
    output wordT        srcA,
    output wordT        srcB,
    output logic        wrEn,
    output wordT        wrData
);

    localparam logic [1:0] sFetch = 2'd0;
    localparam logic [1:0] sExec  = 2'd1;
    localparam logic [1:0] sMem   = 2'd2;

    logic [1:0] state;
    wordT       pc;
    wordT       pcPlus4;
    wordT       pcTarget;
    wordT       nextPc;
    logic       busReq;
    logic       redirect;
    logic       usePc;
    logic       memOp;
    logic [7:0] loadByte;

    assign cyc = busReq;
    assign stb = busReq;

    assign pcPlus4  = pc + wordT'(4);
    assign pcTarget = pc + imm;  // jal and taken branches

    // auipc and jal compute from the PC
    assign usePc = (instr.rView.opcode == opAuipc) || (jumpSrc && !jRetSrc);
    assign srcA  = usePc ? pc : rd1;
    assign srcB  = aluSrc ? imm : rd2;

    assign redirect = pcSrc && (jumpSrc || (branch && zero));

    always_comb begin
        if (!redirect) begin
            nextPc = pcPlus4;
        end else if (jRetSrc) begin
            nextPc = {aluResult[`XLEN-1:1], 1'b0};
        end else begin
            nextPc = pcTarget;
        end
    end

    assign memOp    = resultSrc || memWrite;
    assign loadByte = datMiso[8*adr[1:0] +: 8];  // Lane picked by low address bits

    // Execute writes ALU or link, lbu writes on its ack
    assign wrEn = ((state == sExec) && regWrite && !resultSrc) ||
                  ((state == sMem) && ack && regWrite && resultSrc);
    assign wrData = (state == sMem) ? {{(`XLEN-8){1'b0}}, loadByte} :
                    (jumpSrc ? pcPlus4 : aluResult);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= sFetch;
            pc      <= `RESET_PC;
            busReq  <= 1'b0;
            we      <= 1'b0;
            adr     <= '0;
            sel     <= '0;
            datMosi <= '0;
            instr   <= '0;
        end else begin
            case (state)
                sFetch: begin
                    if (!busReq) begin  // Only the first fetch after reset
                        busReq <= 1'b1;
                        adr    <= pc;
                        sel    <= 4'hf;
                    end else if (ack) begin
                        instr  <= datMiso;
                        busReq <= 1'b0;
                        state  <= sExec;
                    end
                end
                sExec: begin
                    pc     <= nextPc;
                    busReq <= 1'b1;
                    if (memOp) begin
                        adr     <= aluResult;
                        we      <= memWrite;
                        sel     <= 4'b0001 << aluResult[1:0];
                        datMosi <= {4{rd2[7:0]}};  // Byte on every lane
                        state   <= sMem;
                    end else begin
                        adr   <= nextPc;
                        sel   <= 4'hf;
                        state <= sFetch;
                    end
                end
                sMem: begin
                    if (ack) begin  // Next fetch starts right away
                        adr   <= pc;
                        we    <= 1'b0;
                        sel   <= 4'hf;
                        state <= sFetch;
                    end
                end
                default: state <= sFetch;
            endcase
        end
    end

endmodule

// File: src/cpuTop.sv
module cpuTop import cpuPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    output logic        cyc,
    output logic        stb,
    output logic        we,
    output wordT        adr,
    output wordT        datMosi,
    output logic [3:0]  sel,
    input  logic        ack,
    input  wordT        datMiso
);

    instrT   instr;
    logic    regWrite;
    aluOpT   aluCtrl;
    logic    aluSrc;
    immTypeT immSrc;
    logic    pcSrc;
    logic    memWrite;
    logic    resultSrc;
    logic    jumpSrc;
    logic    jRetSrc;
    logic    branch;
    wordT    imm;
    wordT    rd1;
    wordT    rd2;
    wordT    srcA;
    wordT    srcB;
    wordT    aluResult;
    logic    zero;
    logic    wrEn;
    wordT    wrData;

    cpuSequencer seq (
        .clk(clk), .rstN(rstN),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datMosi(datMosi), .sel(sel),
        .ack(ack), .datMiso(datMiso),
        .instr(instr),
        .regWrite(regWrite), .aluSrc(aluSrc), .pcSrc(pcSrc), .memWrite(memWrite),
        .resultSrc(resultSrc), .jumpSrc(jumpSrc), .jRetSrc(jRetSrc), .branch(branch),
        .imm(imm), .rd1(rd1), .rd2(rd2), .aluResult(aluResult), .zero(zero),
        .srcA(srcA), .srcB(srcB), .wrEn(wrEn), .wrData(wrData)
    );

    controlUnit decoder (
        .opcode(instr.rView.opcode), .funct3(instr.rView.funct3),
        .funct7(instr.rView.funct7[5]),  // Instruction bit 30
        .regWrite(regWrite), .aluCtrl(aluCtrl), .aluSrc(aluSrc), .immSrc(immSrc),
        .pcSrc(pcSrc), .memWrite(memWrite), .resultSrc(resultSrc),
        .jumpSrc(jumpSrc), .jRetSrc(jRetSrc), .branch(branch)
    );

    immExtend immGen (
        .instr(instr), .immSrc(immSrc), .imm(imm)
    );

    regFile regs (
        .clk(clk), .rstN(rstN),
        .rs1(instr.iView.rs1), .rs2(instr.rView.rs2), .rd(instr.iView.rd),
        .wrEn(wrEn), .wrData(wrData), .rd1(rd1), .rd2(rd2)
    );

    alu aluUnit (
        .aluCtrl(aluCtrl), .srcA(srcA), .srcB(srcB), .result(aluResult), .zero(zero)
    );

endmodule

// File: bench/cpuTb_asserts.sv
module cpuTbAsserts import cpuPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic        ack,
    input  wordT        adr,
    input  wordT        datMosi,
    input  logic [3:0]  sel
);
    timeunit 1ns;
    timeprecision 100ps;

    stbInCyc: assert property (@(posedge clk) disable iff (!rstN) stb |-> cyc)
        else $error("stb high outside a bus cycle");

    // Request frozen until the slave acks
    holdRequest: assert property (@(posedge clk) disable iff (!rstN)
        (stb && !ack) |=> (stb && $stable(adr) && $stable(sel) && $stable(we)))
        else $error("Bus request changed before ack");

    holdWriteData: assert property (@(posedge clk) disable iff (!rstN)
        (stb && we && !ack) |=> $stable(datMosi))
        else $error("Write data changed before ack");

    idleInReset: assert property (@(posedge clk) !rstN |-> !cyc)
        else $error("cyc high during reset");

endmodule

bind cpuTop cpuTbAsserts busAsserts (.*);

// File: bench/cpuTb.sv
`include "cpu_consts.svh"

module cpuTb import cpuPkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MemWords     = 256;
    localparam int StimWords    = 512;
    localparam int StimFlagIdx  = 256;  // Wait states on the second pass
    localparam int StimCountIdx = 257;
    localparam int StimRecBase  = 258;  // Address, byte pairs
    localparam int StoreTimeout = 4000;

    logic        clk;
    logic        rstN;
    logic        cyc;
    logic        stb;
    logic        we;
    wordT        adr;
    wordT        datMosi;
    logic [3:0]  sel;
    logic        ack;
    wordT        datMiso;

    logic [31:0] stim [StimWords];
    wordT        mem [MemWords];
    integer      seed;
    int          waitLeft;
    bit          waitOn;
    bit          firstReq;
    int          storeIdx;
    int          nStores;

    cpuTop UUT (
        .clk(clk), .rstN(rstN),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datMosi(datMosi), .sel(sel),
        .ack(ack), .datMiso(datMiso)
    );

    always #10 clk = ~clk;

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "Run stopped");
    endtask

    task automatic checkAddr(input string name, input wordT expVal, input wordT actVal);
        if (actVal !== expVal) begin
            failRun($sformatf("FAIL %s expected %h actual %h", name, expVal, actVal));
        end
    endtask

    task automatic checkByte(input string name, input logic [7:0] expVal,
                             input logic [7:0] actVal);
        if (actVal !== expVal) begin
            failRun($sformatf("FAIL %s expected %h actual %h", name, expVal, actVal));
        end
    endtask

    task automatic checkSel(input string name, input logic [3:0] expVal,
                            input logic [3:0] actVal);
        if (actVal !== expVal) begin
            failRun($sformatf("FAIL %s expected %b actual %b", name, expVal, actVal));
        end
    endtask

    function automatic int drawWait();
        if (!waitOn) begin
            return 0;
        end
        return $unsigned($random(seed)) % 4;
    endfunction

    task automatic loadMemory();
        for (int i = 0; i < MemWords; i++) begin
            if ($isunknown(stim[i])) begin
                mem[i] = 32'hA5A5_0000 | i;  // Fill outside program and data
            end else begin
                mem[i] = stim[i];
            end
        end
    endtask

    // Compares one store with the next expected record
    task automatic checkStore();
        wordT       expAddr;
        logic [7:0] expByte;
        if (storeIdx >= nStores) begin
            failRun($sformatf("Unexpected extra store to address %h", adr));
        end else begin
            expAddr = stim[StimRecBase + 2 * storeIdx];
            expByte = stim[StimRecBase + 2 * storeIdx + 1][7:0];
            checkAddr($sformatf("store %0d adr", storeIdx), expAddr, adr);
            checkSel($sformatf("store %0d sel", storeIdx), 4'b0001 << expAddr[1:0], sel);
            for (int b = 0; b < 4; b++) begin  // Byte repeated on every lane
                checkByte($sformatf("store %0d byte lane %0d", storeIdx, b), expByte,
                          datMosi[8 * b +: 8]);
            end
            storeIdx++;
        end
    endtask

    task automatic serveRequest();
        int idx;
        idx = adr[9:2];
        if (we) begin
            checkStore();
            for (int b = 0; b < 4; b++) begin
                if (sel[b]) begin
                    mem[idx][8 * b +: 8] = datMosi[8 * b +: 8];
                end
            end
        end
        datMiso = mem[idx];
    endtask

    // Wishbone slave, one decision per falling edge
    always @(negedge clk) begin
        ack = 1'b0;
        if (rstN && cyc && stb) begin
            if (firstReq) begin
                checkAddr("first fetch adr", `RESET_PC, adr);
                checkSel("first fetch sel", 4'hf, sel);
                if (we) begin
                    failRun("First bus cycle after reset is a write");
                end
                firstReq = 1'b0;
            end
            if (waitLeft > 0) begin
                waitLeft--;
            end else begin
                serveRequest();
                ack      = 1'b1;
                waitLeft = drawWait();
            end
        end
    end

    task automatic runPass(input bit withWaits);
        int cycles;
        rstN     = 1'b0;
        waitOn   = withWaits;
        waitLeft = 0;
        storeIdx = 0;
        firstReq = 1'b1;
        loadMemory();
        repeat (4) @(negedge clk);
        rstN   = 1'b1;
        cycles = 0;
        while (storeIdx < nStores && cycles < StoreTimeout) begin
            @(negedge clk);
            cycles++;
        end
        if (storeIdx < nStores) begin
            failRun($sformatf("Timed out after %0d of %0d stores", storeIdx, nStores));
        end
        repeat (20) @(negedge clk);  // Program spins, any extra store shows up
    endtask

    initial begin
        clk     = 1'b0;
        rstN    = 1'b0;
        ack     = 1'b0;
        datMiso = '0;
        seed    = 32'hc57ea0eb;
        $readmemh("bench/cpu_stim.txt", stim);
        nStores = stim[StimCountIdx];
        runPass(1'b0);
        runPass(stim[StimFlagIdx][0]);  // Same store sequence expected
        $display("Testbench passed");
        $finish;
    end

endmodule

// File: src.f
+incdir+src
src/cpuPkg.sv
src/controlUnit.sv
src/immExtend.sv
src/regFile.sv
src/alu.sv
src/cpuSequencer.sv
src/cpuTop.sv
bench/cpuTb_asserts.sv
bench/cpuTb.sv

// File: bench/cpu_stim.txt
// Hex words loaded in order from each @ word address
// @000 program, @0C0 data word, @100 wait flag, @101 store count, @102 address and byte
@000
03500093 00C00113 20000513  // addi x1,x0,0x35  addi x2,x0,12  addi x10,x0,0x200
002081B3 00350023           // add x3,x1,x2  sb x3,0(x10)
40208233 004500A3           // sub x4,x1,x2  sb x4,1(x10)
00209293 00550123           // slli x5,x1,2  sb x5,2(x10)
0020C333 006501A3           // xor x6,x1,x2  sb x6,3(x10)
0020D393 00750223           // srli x7,x1,2  sb x7,4(x10)
0400E413 0020F4B3           // ori x8,x1,0x40  and x9,x1,x2
008502A3 00950323           // sb x8,5(x10)  sb x9,6(x10)
10254583 0045D613           // lbu x11,0x102(x10)  srli x12,x11,4
00B503A3 00C50423           // sb x11,7(x10)  sb x12,8(x10)
00208463 001504A3           // beq x1,x2 not taken  sb x1,9(x10)
00209463 00250523           // bne x1,x2 taken  skipped store
00318463 00250523           // beq x3,x3 taken  skipped store
00109463 00250523           // bne x1,x1 not taken  sb x2,10(x10)
123456B7 00C6D713 00E505A3  // lui x13,0x12345  srli x14,x13,12  sb x14,11(x10)
00001797 00F50623           // auipc x15,1 at 0x80  sb x15,12(x10)
0087D813 010506A3           // srli x16,x15,8  sb x16,13(x10)
010008EF 012507A3 0140006F  // jal x17,0xA0  sb x18,15(x10)  jal x0,0xAC
00250723                    // skipped store
01150723 00088967 00250723  // sb x17,14(x10)  jalr x18,0(x17)  skipped store
FFFFFFFF 00150823 0000006F  // unknown opcode  sb x1,16(x10)  spin
@0C0
11A7C3E5                    // lbu source word at 0x300
@100
00000001
00000011
00000200 41  00000201 29  00000202 D4  00000203 39
00000204 0D  00000205 75  00000206 04
00000207 A7  00000208 0A    // lbu zero extension
00000209 35  0000020A 0C    // Branch path
0000020B 45  0000020C 80  0000020D 10
0000020E 94  0000020F A8    // jal and jalr link values
00000210 35
